// File: Bender.yml
package:
  name: memory_stage

sources:
  - include_dirs:
      - include
    files:
      - source/mem_stage_pkg.sv
      - source/single_transfer.sv
      - source/block_transfer.sv
      - source/mem_result_merge.sv
      - source/memory_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_bus_model.sv
      - testbench/tb_memory_stage.sv

// File: all.f
+incdir+include
source/mem_stage_pkg.sv
source/single_transfer.sv
source/block_transfer.sv
source/mem_result_merge.sv
source/memory_stage.sv
testbench/tb_bus_model.sv
testbench/tb_memory_stage.sv

// File: include/arm_decode.svh
`ifndef ARM_DECODE_SVH
`define ARM_DECODE_SVH

localparam int l_bit = 20; // load when set, store when clear.
localparam int w_bit = 21; // base writeback.
localparam int b_bit = 22; // byte transfer.
localparam int u_bit = 23; // offset added when set.
localparam int p_bit = 24; // pre-index when set.

localparam int rn_lsb = 16;
localparam int rd_lsb = 12;

// LDR/STR with a register offset and bit 4 set is an undefined encoding.
localparam logic [31:0] decode_ldrstr_undefined =
	32'b????_011?_????_????_????_????_???1_????;
localparam logic [31:0] decode_ldrstr =
	32'b????_01??_????_????_????_????_????_????;
localparam logic [31:0] decode_ldmstm =
	32'b????_100?_????_????_????_????_????_????;

`endif

// File: source/block_transfer.sv
`timescale 1ns/1ns

module block_transfer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_stage_pkg::stage_in_t  stage_in,
	input  logic                      rw_wait,
	input  logic [31:0]               rd_data,
	input  logic [31:0]               st_data,
	output logic [3:0]                st_read,
	output mem_stage_pkg::unit_out_t  result
);
	import mem_stage_pkg::*;

	logic        active;
	logic        is_load;
	logic        started;
	logic [15:0] regs;
	logic [15:0] regs_left;
	logic [3:0]  cur_reg;
	logic [31:0] addr;
	logic [4:0]  count;
	logic [31:0] span;
	logic [31:0] start_addr;
	logic        beat_done;

	function automatic logic [4:0] pop_count(input logic [15:0] list);
		logic [4:0] n;
		n = 5'd0;
		for (int i = 0; i < 16; i++) begin
			n = n + 5'(list[i]);
		end
		return n;
	endfunction

	function automatic logic [3:0] lowest_reg(input logic [15:0] list);
		logic [3:0] num;
		num = 4'h0;
		for (int i = 15; i >= 0; i--) begin
			if (list[i]) begin
				num = 4'(i);
			end
		end
		return num;
	endfunction

	assign active = !stage_in.bubble && (insn_class(stage_in.insn) == cls_block);
	assign is_load = stage_in.insn[l_bit];

	// ************************************************************
	// start address and base writeback value
	// ************************************************************

	assign count = pop_count(stage_in.op1[15:0]); // op1 is held for the whole sequence.
	assign span = {25'h0, count, 2'b00};

	always_comb begin
		case ({stage_in.insn[p_bit], stage_in.insn[u_bit]})
			2'b01: start_addr = stage_in.op0; // increment after.
			2'b11: start_addr = stage_in.op0 + 32'd4; // increment before.
			2'b00: start_addr = stage_in.op0 - span + 32'd4; // decrement after.
			default: start_addr = stage_in.op0 - span; // decrement before.
		endcase
	end

	assign regs_left = regs & ~(16'h0001 << cur_reg);
	assign beat_done = active && started && (regs != 16'h0) && !rw_wait;
	assign st_read = cur_reg;

	// ************************************************************
	// beat sequencing
	// ************************************************************

	always_comb begin
		result = '0;
		if (active && started) begin
			if (regs != 16'h0) begin
				result.bus.addr = {addr[31:2], 2'b00};
				result.bus.rd = is_load;
				result.bus.wr = !is_load;
				result.bus.wdata = st_data;
				result.bus.byte_en = 4'hf;
				if (is_load && !rw_wait) begin
					result.wb.write_reg = 1'b1;
					result.wb.write_num = cur_reg;
					result.wb.write_data = rd_data;
				end
			end else if (stage_in.insn[w_bit]) begin
				result.wb.write_reg = 1'b1;
				result.wb.write_num = stage_in.insn[rn_lsb +: 4];
				result.wb.write_data = stage_in.insn[u_bit] ? stage_in.op0 + span
					: stage_in.op0 - span;
			end
		end
		result.stall = active && (!started || (regs != 16'h0)); // low only in the final cycle.
		result.hold_bubble = result.stall;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
			regs <= 16'h0;
			cur_reg <= 4'h0;
		end else if (!active) begin
			started <= 1'b0;
			regs <= 16'h0;
		end else if (!started) begin
			started <= 1'b1;
			regs <= stage_in.op1[15:0]; // first cycle only latches the list.
			cur_reg <= lowest_reg(stage_in.op1[15:0]);
		end else if (regs == 16'h0) begin
			started <= 1'b0;
		end else if (!rw_wait) begin
			regs <= regs_left;
			cur_reg <= lowest_reg(regs_left);
		end
	end

	always_ff @(posedge clk) begin
		if (!started) begin
			addr <= start_addr;
		end else if (beat_done) begin
			addr <= addr + 32'd4;
		end
	end

	list_only_shrinks: assert property (@(posedge clk) disable iff (!rst_n)
		started |=> (!started || ((regs & ~$past(regs)) == 16'h0)))
		else $error("block_transfer: register list gained a bit mid sequence");

	no_request_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(started && (regs == 16'h0)) |-> !(result.bus.rd || result.bus.wr))
		else $error("block_transfer: bus request after the list emptied");

endmodule

// File: source/mem_result_merge.sv
`timescale 1ns/1ns

module mem_result_merge (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_stage_pkg::stage_in_t  stage_in,
	input  mem_stage_pkg::unit_out_t  single_res,
	input  mem_stage_pkg::unit_out_t  block_res,
	output mem_stage_pkg::bus_req_t   bus,
	output logic                      outstall,
	output logic                      outbubble,
	output logic [31:0]               outpc,
	output logic [31:0]               outinsn,
	output mem_stage_pkg::wb_t        out_wb
);
	import mem_stage_pkg::*;

	insn_class_e cls;
	unit_out_t   sel;
	wb_t         next_wb;
	logic        next_bubble;
	logic        out_write_reg;
	logic [3:0]  out_write_num;
	logic [31:0] out_write_data;

	assign cls = insn_class(stage_in.insn);

	// ************************************************************
	// unit select
	// ************************************************************

	always_comb begin
		case (cls)
			cls_single: sel = single_res;
			cls_block: sel = block_res;
			default: sel = '0; // undefined and other instructions never touch the bus.
		endcase
	end

	assign bus = sel.bus;
	assign outstall = sel.stall;
	assign next_bubble = stage_in.bubble || sel.hold_bubble;

	always_comb begin
		if (sel.wb.write_reg) begin
			next_wb = sel.wb;
		end else if (sel.stall) begin
			next_wb = '0; // the upstream write goes out once, when the instruction leaves.
		end else begin
			next_wb = stage_in.wb;
		end
	end

	// ************************************************************
	// stage output registers
	// ************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outbubble <= 1'b1;
			out_write_reg <= 1'b0;
		end else begin
			outbubble <= next_bubble;
			out_write_reg <= next_wb.write_reg;
		end
	end

	always_ff @(posedge clk) begin
		outpc <= stage_in.pc;
		outinsn <= stage_in.insn;
		out_write_num <= next_wb.write_num;
		out_write_data <= next_wb.write_data;
	end

	assign out_wb = '{write_reg: out_write_reg, write_num: out_write_num,
		write_data: out_write_data};

	// the units gate their own requests on the bubble flag.
	bubble_no_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		stage_in.bubble |-> !(bus.rd || bus.wr))
		else $error("mem_result_merge: bus strobe raised for a bubble");

endmodule

// File: source/mem_stage_pkg.sv
package mem_stage_pkg;

	`include "arm_decode.svh"

	typedef struct packed {
		logic        write_reg;
		logic [3:0]  write_num;
		logic [31:0] write_data;
	} wb_t;

	typedef struct packed {
		logic [31:0] addr; // always word aligned.
		logic        rd;
		logic        wr;
		logic [31:0] wdata;
		logic [3:0]  byte_en;
	} bus_req_t;

	typedef struct packed {
		logic        bubble;
		logic [31:0] pc;
		logic [31:0] insn;
		logic [31:0] op0; // base register.
		logic [31:0] op1; // offset or register list.
		logic [31:0] op2; // store data for single transfers.
		wb_t         wb;
	} stage_in_t;

	typedef struct packed {
		bus_req_t bus;
		wb_t      wb;
		logic     stall;
		logic     hold_bubble;
	} unit_out_t;

	typedef enum logic [1:0] {cls_none, cls_single, cls_undef, cls_block} insn_class_e;

	function automatic insn_class_e insn_class(input logic [31:0] insn);
		insn_class_e cls;
		casez (insn)
			decode_ldrstr_undefined: cls = cls_undef; // must win over the plain LDR/STR pattern.
			decode_ldrstr: cls = cls_single;
			decode_ldmstm: cls = cls_block;
			default: cls = cls_none;
		endcase
		return cls;
	endfunction

endpackage

// File: source/memory_stage.sv
`timescale 1ns/1ns

module memory_stage (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_stage_pkg::stage_in_t  stage_in,
	input  logic                      rw_wait,
	input  logic [31:0]               rd_data,
	input  logic [31:0]               st_data,
	output mem_stage_pkg::bus_req_t   bus,
	output logic [3:0]                st_read,
	output logic                      outstall,
	output logic                      outbubble,
	output logic [31:0]               outpc,
	output logic [31:0]               outinsn,
	output mem_stage_pkg::wb_t        out_wb
);
	import mem_stage_pkg::*;

	unit_out_t single_res;
	unit_out_t block_res;

	single_transfer u_single_transfer (
		.clk      (clk),
		.rst_n    (rst_n),
		.stage_in (stage_in),
		.rw_wait  (rw_wait),
		.rd_data  (rd_data),
		.result   (single_res)
	);

	// only the block unit reads the register file for store data.
	block_transfer u_block_transfer (
		.clk      (clk),
		.rst_n    (rst_n),
		.stage_in (stage_in),
		.rw_wait  (rw_wait),
		.rd_data  (rd_data),
		.st_data  (st_data),
		.st_read  (st_read),
		.result   (block_res)
	);

	mem_result_merge u_mem_result_merge (
		.clk        (clk),
		.rst_n      (rst_n),
		.stage_in   (stage_in),
		.single_res (single_res),
		.block_res  (block_res),
		.bus        (bus),
		.outstall   (outstall),
		.outbubble  (outbubble),
		.outpc      (outpc),
		.outinsn    (outinsn),
		.out_wb     (out_wb)
	);

endmodule

// File: source/single_transfer.sv
`timescale 1ns/1ns

module single_transfer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mem_stage_pkg::stage_in_t  stage_in,
	input  logic                      rw_wait,
	input  logic [31:0]               rd_data,
	output mem_stage_pkg::unit_out_t  result
);
	import mem_stage_pkg::*;

	logic        active;
	logic        is_load;
	logic        is_byte;
	logic        base_wb;
	logic        step;
	logic        step_next;
	logic [31:0] offset_addr;
	logic [31:0] xfer_addr;
	logic [1:0]  lane;
	logic [63:0] rot64;
	logic [31:0] rot_data;
	logic [31:0] load_data;

	assign active = !stage_in.bubble && (insn_class(stage_in.insn) == cls_single);
	assign is_load = stage_in.insn[l_bit];
	assign is_byte = stage_in.insn[b_bit];
	assign base_wb = stage_in.insn[w_bit];

	// ************************************************************
	// address generation and read alignment
	// ************************************************************

	assign offset_addr = stage_in.insn[u_bit] ? stage_in.op0 + stage_in.op1
		: stage_in.op0 - stage_in.op1;
	assign xfer_addr = stage_in.insn[p_bit] ? offset_addr : stage_in.op0; // post-index uses the base.
	assign lane = xfer_addr[1:0];

	assign rot64 = {rd_data, rd_data} >> {lane, 3'b000}; // rotate right by the byte offset.
	assign rot_data = rot64[31:0];
	assign load_data = is_byte ? {24'h0, rot_data[7:0]} : rot_data;

	// ************************************************************
	// request, stall and writeback
	// ************************************************************

	always_comb begin
		result = '0;
		step_next = 1'b0;
		if (active) begin
			if (!step) begin
				result.bus.addr = {xfer_addr[31:2], 2'b00};
				result.bus.rd = is_load;
				result.bus.wr = !is_load;
				result.bus.wdata = is_byte ? {4{stage_in.op2[7:0]}} : stage_in.op2;
				result.bus.byte_en = is_byte ? (4'b0001 << lane) : 4'hf;
				result.stall = rw_wait || (is_load && base_wb); // LDR with W needs a second cycle.
				if (!rw_wait) begin
					if (is_load) begin
						result.wb.write_reg = 1'b1;
						result.wb.write_num = stage_in.insn[rd_lsb +: 4];
						result.wb.write_data = load_data;
						step_next = base_wb;
					end else if (base_wb) begin
						result.wb.write_reg = 1'b1;
						result.wb.write_num = stage_in.insn[rn_lsb +: 4];
						result.wb.write_data = offset_addr;
					end
				end
			end else begin
				// the load data went out last cycle, so the base follows now.
				result.wb.write_reg = 1'b1;
				result.wb.write_num = stage_in.insn[rn_lsb +: 4];
				result.wb.write_data = offset_addr;
			end
			result.hold_bubble = result.stall;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step <= 1'b0;
		end else begin
			step <= step_next;
		end
	end

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(result.bus.rd && result.bus.wr))
		else $error("single_transfer: read and write requested together");

endmodule

// File: testbench/tb_bus_model.sv
`timescale 1ns/1ns

module tb_bus_model (
	input  logic                     clk,
	input  logic                     rst_n,
	input  mem_stage_pkg::bus_req_t  bus,
	input  logic [3:0]               st_read,
	output logic                     rw_wait,
	output logic [31:0]              rd_data,
	output logic [31:0]              st_data
);
	import mem_stage_pkg::*;

	logic [31:0] mem [0:255];
	logic [31:0] shadow [0:255]; // expected contents, kept by the testbench.
	integer      seed;
	int          wait_run;

	initial begin
		seed = 28;
		for (int i = 0; i < 256; i++) begin
			mem[i] = i * 32'h9e37_79b1 + 32'h0100_0000; // every address bit shows in the word.
			shadow[i] = i * 32'h9e37_79b1 + 32'h0100_0000;
		end
	end

	assign rd_data = mem[bus.addr[9:2]];
	assign st_data = 32'h5a00_0000 + st_read * 32'h0001_0011; // register file read port.

	// ************************************************************
	// wait states, at most three in a row
	// ************************************************************

	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rw_wait <= 1'b0;
			wait_run <= 0;
		end else if (wait_run >= 3 || ($random(seed) & 3) != 0) begin
			rw_wait <= 1'b0;
			wait_run <= 0;
		end else begin
			rw_wait <= 1'b1;
			wait_run <= wait_run + 1;
		end
	end

	always @(posedge clk) begin
		if (rst_n && bus.wr && !rw_wait) begin
			for (int k = 0; k < 4; k++) begin
				if (bus.byte_en[k]) begin
					mem[bus.addr[9:2]][k * 8 +: 8] <= bus.wdata[k * 8 +: 8];
				end
			end
		end
	end

endmodule

// File: testbench/tb_memory_stage.sv
`timescale 1ns/1ns

module tb_memory_stage;
	import mem_stage_pkg::*;

	typedef struct packed {
		logic [1:0]  kind; // 0 pass through, 1 single, 2 block.
		logic        bubble;
		logic        rand_list;
		logic [31:0] insn;
		logic [31:0] op0;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] pre;
	} row_t;

	localparam int max_rows = 24;
	localparam int cycle_limit = 16 + max_rows * ((16 + 3) * 4 + 4) + 100;

	logic        clk;
	logic        rst_n;
	stage_in_t   stage_in;
	bus_req_t    bus;
	logic        rw_wait;
	logic [31:0] rd_data;
	logic [31:0] st_data;
	logic [3:0]  st_read;
	logic        outstall;
	logic        outbubble;
	logic [31:0] outpc;
	logic [31:0] outinsn;
	wb_t         out_wb;
	row_t        rows [$];
	wb_t         exp_q [$];
	wb_t         got_q [$];
	int          errors;
	int          tests_ok;
	int          cycles;
	integer      seed;

	memory_stage u_memory_stage (
		.clk(clk), .rst_n(rst_n), .stage_in(stage_in), .rw_wait(rw_wait),
		.rd_data(rd_data), .st_data(st_data), .bus(bus), .st_read(st_read),
		.outstall(outstall), .outbubble(outbubble), .outpc(outpc),
		.outinsn(outinsn), .out_wb(out_wb)
	);

	tb_bus_model u_bus (
		.clk(clk), .rst_n(rst_n), .bus(bus), .st_read(st_read),
		.rw_wait(rw_wait), .rd_data(rd_data), .st_data(st_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (rst_n && out_wb.write_reg) begin
			got_q.push_back(out_wb); // one registered writeback per cycle.
		end
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	function automatic wb_t wb_of(input logic [3:0] num, input logic [31:0] data);
		wb_t w;
		w.write_reg = 1'b1;
		w.write_num = num;
		w.write_data = data;
		return w;
	endfunction

	function automatic logic [31:0] ls_insn(input logic p, u, b, w, l, input logic [3:0] rn, rd);
		return {4'he, 3'b010, p, u, b, w, l, rn, rd, 12'h000};
	endfunction

	function automatic logic [31:0] lsm_insn(input logic p, u, w, l, input logic [3:0] rn);
		return {4'he, 3'b100, p, u, 1'b0, w, l, rn, 16'h0000};
	endfunction

	task automatic add_row(input logic [1:0] kind, input logic bubble, rand_list,
			input logic [31:0] insn, op0, op1, op2, pre);
		row_t r;
		r = '{kind, bubble, rand_list, insn, op0, op1, op2, pre};
		rows.push_back(r);
	endtask

	// ************************************************************
	// expected writebacks and memory from the transfer rules
	// ************************************************************

	task automatic predict(input row_t r, input logic [31:0] list, input int idx);
		logic [31:0] off_a;
		logic [31:0] xa;
		logic [31:0] w;
		logic [31:0] a;
		logic [3:0]  rn;
		int          n;
		rn = r.insn[rn_lsb +: 4];
		off_a = r.insn[u_bit] ? r.op0 + list : r.op0 - list;
		if (r.kind == 2'd1) begin
			xa = r.insn[p_bit] ? off_a : r.op0;
			if (r.insn[l_bit]) begin
				w = u_bus.shadow[xa[9:2]];
				w = (w >> (8 * xa[1:0])) | (w << (32 - 8 * xa[1:0]));
				w = r.insn[b_bit] ? {24'h0, w[7:0]} : w;
				exp_q.push_back(wb_of(r.insn[rd_lsb +: 4], w));
			end else if (r.insn[b_bit]) begin
				u_bus.shadow[xa[9:2]][8 * xa[1:0] +: 8] = r.op2[7:0];
			end else begin
				u_bus.shadow[xa[9:2]] = r.op2;
			end
			if (r.insn[w_bit]) begin
				exp_q.push_back(wb_of(rn, off_a));
			end
		end else if (r.kind == 2'd2) begin
			n = $countones(list[15:0]);
			case ({r.insn[p_bit], r.insn[u_bit]})
				2'b01: a = r.op0;
				2'b11: a = r.op0 + 4;
				2'b00: a = r.op0 - 4 * n + 4;
				default: a = r.op0 - 4 * n;
			endcase
			for (int k = 0; k < 16; k++) begin
				if (list[k]) begin
					if (r.insn[l_bit]) begin
						exp_q.push_back(wb_of(k, u_bus.shadow[a[9:2]]));
					end else begin
						u_bus.shadow[a[9:2]] = 32'h5a00_0000 + k * 32'h0001_0011;
					end
					a = a + 4;
				end
			end
			if (r.insn[w_bit]) begin
				exp_q.push_back(wb_of(rn, r.insn[u_bit] ? r.op0 + 4 * n : r.op0 - 4 * n));
			end
		end else begin
			exp_q.push_back(wb_of(4'h7, 32'hfeed_0000 + idx)); // upstream write passes.
		end
	endtask

	task automatic run_row(input int idx);
		row_t        r;
		logic [31:0] list;
		logic        stalled;
		int          errs_before;
		int          held;
		int          waits;
		int          exp_held;
		r = rows[idx];
		errs_before = errors;
		held = 0;
		waits = 0;
		list = r.rand_list ? {16'h0, 16'($random(seed))} : r.op1;
		u_bus.mem[r.op0[9:2]] = r.pre;
		u_bus.shadow[r.op0[9:2]] = r.pre;
		predict(r, list, idx);
		@(negedge clk);
		stage_in.bubble = r.bubble;
		stage_in.pc = 32'h0000_1000 + 4 * idx;
		stage_in.insn = r.insn;
		stage_in.op0 = r.op0;
		stage_in.op1 = list;
		stage_in.op2 = r.op2;
		stage_in.wb = (r.kind == 2'd0) ? wb_of(4'h7, 32'hfeed_0000 + idx) : '0;
		forever begin
			#10;
			stalled = outstall;
			held++;
			if ((bus.rd || bus.wr) && rw_wait) begin
				waits++; // a beat held by the bus.
			end
			if (r.kind == 2'd0) begin
				check(bus.rd || bus.wr, 0, "bus strobe for a non-transfer");
			end
			@(negedge clk);
			check(outbubble, stalled || r.bubble, "outbubble");
			if (!stalled) begin
				check(outpc, 32'h0000_1000 + 4 * idx, "outpc");
				check(outinsn, r.insn, "outinsn");
				break;
			end
		end
		case (r.kind)
			2'd1: exp_held = waits + ((r.insn[l_bit] && r.insn[w_bit]) ? 2 : 1);
			2'd2: exp_held = waits + 2 + $countones(list[15:0]); // latch, beats, final.
			default: exp_held = 1;
		endcase
		check(held, exp_held, "cycles held");
		stage_in = '0;
		stage_in.bubble = 1'b1;
		repeat (2) @(negedge clk);
		check(got_q.size(), exp_q.size(), "writeback count");
		for (int j = 0; j < got_q.size() && j < exp_q.size(); j++) begin
			check(got_q[j], exp_q[j], $sformatf("writeback %0d", j));
		end
		for (int k = 0; k < 256; k++) begin
			check(u_bus.mem[k], u_bus.shadow[k], $sformatf("memory word %0d", k));
		end
		got_q.delete();
		exp_q.delete();
		if (errors == errs_before) begin
			tests_ok++;
		end
		$display("test %0d insn %h: %s", idx, r.insn, (errors == errs_before) ? "ok" : "errors");
	endtask

	initial begin
		seed = 28;
		errors = 0;
		tests_ok = 0;
		cycles = 0;
		rst_n = 1'b0;
		stage_in = '0;
		stage_in.bubble = 1'b1;
		add_row(1, 0, 0, ls_insn(1, 1, 0, 0, 1, 1, 2), 32'h200, 0, 0, 32'h8765_4321);
		add_row(1, 0, 0, ls_insn(1, 1, 0, 0, 1, 1, 3), 32'h202, 0, 0, 32'h1122_3344);
		for (int k = 0; k < 4; k++) begin
			add_row(1, 0, 0, ls_insn(1, 1, 1, 0, 1, 1, k), 32'h204 + k, 0, 0, 32'ha1b2_c3d4);
		end
		add_row(1, 0, 0, ls_insn(1, 1, 0, 0, 0, 1, 0), 32'h210, 0, 32'h1122_3344, 32'h0);
		add_row(1, 0, 0, ls_insn(1, 1, 1, 0, 0, 1, 0), 32'h215, 0, 32'h0000_00a5, 32'h0);
		add_row(1, 0, 0, ls_insn(1, 1, 1, 0, 0, 1, 0), 32'h21a, 0, 32'h0000_005c, 32'h0);
		add_row(1, 0, 0, ls_insn(1, 1, 0, 1, 1, 3, 4), 32'h220, 8, 0, 32'h0bad_f00d);
		add_row(1, 0, 0, ls_insn(0, 0, 0, 1, 1, 5, 6), 32'h240, 16, 0, 32'hcafe_0001);
		add_row(1, 0, 0, ls_insn(1, 0, 0, 1, 0, 8, 0), 32'h260, 4, 32'h7777_1234, 32'h0);
		add_row(1, 0, 0, ls_insn(0, 1, 0, 1, 0, 9, 0), 32'h270, 12, 32'h6666_4321, 32'h0);
		add_row(2, 0, 1, lsm_insn(0, 1, 1, 1, 10), 32'h300, 0, 0, 32'h3030_0000);
		add_row(2, 0, 1, lsm_insn(1, 1, 1, 1, 10), 32'h300, 0, 0, 32'h3030_0001);
		add_row(2, 0, 1, lsm_insn(0, 0, 1, 1, 10), 32'h300, 0, 0, 32'h3030_0002);
		add_row(2, 0, 1, lsm_insn(1, 0, 1, 1, 10), 32'h300, 0, 0, 32'h3030_0003);
		add_row(2, 0, 0, lsm_insn(0, 1, 1, 1, 11), 32'h300, 0, 0, 32'h3030_0004);
		add_row(2, 0, 1, lsm_insn(0, 1, 1, 0, 12), 32'h380, 0, 0, 32'h0);
		add_row(2, 0, 1, lsm_insn(1, 0, 0, 0, 12), 32'h380, 0, 0, 32'h0);
		add_row(0, 1, 0, ls_insn(1, 1, 0, 0, 1, 1, 2), 32'h200, 0, 0, 32'h8765_4321);
		add_row(0, 0, 0, ls_insn(1, 1, 0, 0, 1, 1, 2) | 32'h0200_0010, 32'h200, 0, 0,
			32'h8765_4321); // register offset with bit 4 set.
		add_row(0, 0, 0, 32'he081_2003, 32'h200, 0, 0, 32'h8765_4321);
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		$display("%0d tests, %0d ok, %0d errors", rows.size(), tests_ok, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
